// File: Makefile
# Verilator build of the power converter control unit testbench

VERILATOR ?= verilator
TOP       ?= tb_pcu
FLAGS     ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sources.f

# Fails unless the pass message shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/bridge_driver.sv
`default_nettype none

module bridge_driver (
  input  wire                             clk,
  input  wire                             rstn,
  input  wire                             i_load,
  input  wire pcu_types_pkg::bridge_out_t i_pattern,
  input  wire                             i_kill,
  output logic                            o_pending,
  output pcu_types_pkg::bridge_out_t      o_bridge
);

  localparam int WW = $clog2(pcu_cfg_pkg::WAIT_STATES + 1);

  logic [WW-1:0]              r_wait;  // Dead-time cycles left
  pcu_types_pkg::bridge_out_t r_next;  // Pattern waiting for the dead time

  always_ff @(posedge clk) begin
    if (i_load) begin
      r_next <= i_pattern;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      r_wait    <= '0;
      o_pending <= 1'b0;
      o_bridge  <= '0;
    end else if (i_kill) begin
      r_wait    <= '0;  // Drops a pattern still waiting
      o_pending <= 1'b0;
      o_bridge  <= '0;
    end else if (i_load) begin
      r_wait    <= WW'(pcu_cfg_pkg::WAIT_STATES);
      o_pending <= 1'b1;
      o_bridge  <= '0;  // All switches open during dead time
    end else if (r_wait != '0) begin
      r_wait <= r_wait - 1'b1;
    end else if (o_pending) begin
      o_bridge  <= r_next;
      o_pending <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hw/cmd_decoder.sv
`default_nettype none

module cmd_decoder (
  input  wire                             clk,
  input  wire                             rstn,
  input  wire                             i_strobe,
  input  wire pcu_types_pkg::cmd_code_t   i_code,
  input  wire                             i_fault,
  input  wire                             i_ramp_busy,
  input  wire                             i_ramp_done,
  input  wire                             i_bridge_pending,
  output logic                            o_ramp_begin,
  output logic                            o_ramp_abort,
  output logic                            o_bridge_load,
  output pcu_types_pkg::bridge_out_t      o_bridge_pattern,
  output logic                            o_bridge_kill,
  output logic                            o_fan
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ARMED,   // START seen, waiting for PAUSE
    ST_DIS0,
    ST_DIS1,
    ST_DIS2,
    ST_FAULT    // Left only by reset
  } dec_state_t;

  dec_state_t r_state;
  logic       r_strobe;
  logic       r_ready;      // Device charged or discharged, bridge may switch
  logic       strobe_fall;
  logic       cmd_ok;

  assign strobe_fall = r_strobe & ~i_strobe;
  assign cmd_ok      = strobe_fall & ~i_bridge_pending;  // Dropped while dead time runs

  function automatic pcu_types_pkg::bridge_out_t pattern_of(
    input pcu_types_pkg::cmd_code_t code
  );
    pcu_types_pkg::bridge_out_t p;
    p = '0;
    case (code)
      pcu_types_pkg::CMD_PLUS: begin
        p.top  = 4'b0001;
        p.bot  = 4'b0010;
        p.plus = 1'b1;
      end
      pcu_types_pkg::CMD_MINUS: begin
        p.top   = 4'b0010;
        p.bot   = 4'b0001;
        p.minus = 1'b1;
      end
      pcu_types_pkg::CMD_BALLAST_P: begin
        p.top     = 4'b0100;
        p.bot     = 4'b1000;
        p.pause_p = 1'b1;
      end
      pcu_types_pkg::CMD_BALLAST_N: begin
        p.top     = 4'b1000;
        p.bot     = 4'b0100;
        p.pause_n = 1'b1;
      end
      default: ;
    endcase
    return p;
  endfunction

  always_ff @(posedge clk) begin
    if (strobe_fall) begin
      o_bridge_pattern <= pattern_of(i_code);
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      r_state       <= ST_IDLE;
      r_strobe      <= 1'b0;
      r_ready       <= 1'b0;
      o_fan         <= 1'b0;
      o_ramp_begin  <= 1'b0;
      o_ramp_abort  <= 1'b0;
      o_bridge_load <= 1'b0;
      o_bridge_kill <= 1'b0;
    end else begin
      r_strobe      <= i_strobe;
      o_ramp_begin  <= 1'b0;
      o_ramp_abort  <= 1'b0;
      o_bridge_load <= 1'b0;
      o_bridge_kill <= 1'b0;
      if (i_ramp_done) begin
        r_ready <= 1'b1;
      end
      if (r_state == ST_FAULT) begin
        r_ready <= 1'b0;
      end else if (i_fault) begin
        r_state       <= ST_FAULT;  // First fault cycle stops everything
        o_ramp_abort  <= 1'b1;
        o_bridge_kill <= 1'b1;
        o_fan         <= 1'b1;
        r_ready       <= 1'b0;
      end else if (cmd_ok) begin
        if (i_code == pcu_types_pkg::CMD_SHUTDOWN) begin
          o_ramp_abort  <= 1'b1;
          o_bridge_kill <= 1'b1;
          o_fan         <= 1'b0;
          r_ready       <= 1'b0;
          r_state       <= ST_IDLE;
        end else begin
          r_state <= ST_IDLE;
          case (r_state)
            ST_IDLE: begin
              case (i_code)
                pcu_types_pkg::CMD_PAUSE: o_bridge_kill <= ~i_ramp_busy;
                pcu_types_pkg::CMD_PLUS, pcu_types_pkg::CMD_MINUS,
                pcu_types_pkg::CMD_BALLAST_P, pcu_types_pkg::CMD_BALLAST_N:
                  o_bridge_load <= ~i_ramp_busy & r_ready;
                pcu_types_pkg::CMD_START:
                  if (!i_ramp_busy) r_state <= ST_ARMED;
                pcu_types_pkg::CMD_DISCHARGE:
                  if (!i_ramp_busy) r_state <= ST_DIS0;
                default: ;
              endcase
            end
            ST_ARMED: begin
              if (i_code == pcu_types_pkg::CMD_PAUSE) begin
                o_ramp_begin  <= 1'b1;  // Bridge off while charging
                o_bridge_kill <= 1'b1;
                o_fan         <= 1'b1;
              end
            end
            ST_DIS0: if (i_code == pcu_types_pkg::CMD_PAUSE) r_state <= ST_DIS1;
            ST_DIS1: if (i_code == pcu_types_pkg::CMD_DISCHARGE) r_state <= ST_DIS2;
            ST_DIS2: if (i_code == pcu_types_pkg::CMD_PAUSE) r_ready <= 1'b1;
            default: ;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/fault_monitor.sv
`default_nettype none

module fault_monitor #(
  parameter int STEP_CYCLES = pcu_cfg_pkg::STEP_CYCLES_DEFAULT
) (
  input  wire                         clk,
  input  wire                         rstn,
  input  wire pcu_types_pkg::fault_t  i_faults,
  output logic                        o_fault,
  output pcu_types_pkg::fault_flags_t o_flags,
  output logic                        o_led
);

  localparam int TW = $clog2(STEP_CYCLES);

  logic [TW-1:0] r_led_timer;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_fault     <= 1'b0;
      o_flags     <= '0;
      o_led       <= 1'b0;
      r_led_timer <= TW'(STEP_CYCLES - 1);
    end else begin
      o_fault      <= o_fault | (|i_faults);  // Cleared only by reset
      o_flags.stop <= o_flags.stop | i_faults.stop_k;
      o_flags.avv  <= o_flags.avv | i_faults.err_u;
      o_flags.avi  <= o_flags.avi | i_faults.err_i;
      o_flags.td   <= o_flags.td | i_faults.bt;
      o_flags.erbd <= o_flags.erbd | i_faults.err_dr;
      if (r_led_timer != '0) begin
        r_led_timer <= r_led_timer - 1'b1;
      end else begin
        o_led       <= ~o_led;
        // Eight times faster blink once a fault is latched
        r_led_timer <= o_fault ? TW'(STEP_CYCLES / 8 - 1) : TW'(STEP_CYCLES - 1);
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/input_filter.sv
`default_nettype none

module input_filter #(
  parameter int LEN = 8
) (
  input  wire  clk,
  input  wire  rstn,
  input  wire  i_line,
  output logic o_line
);

  localparam int CW = $clog2(LEN);

  logic          r_sample;  // Input register, also the synchronizer stage
  logic [CW-1:0] r_count;   // Differing samples seen so far

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      r_sample <= 1'b0;
      r_count  <= '0;
      o_line   <= 1'b0;
    end else begin
      r_sample <= i_line;
      if (r_sample == o_line) begin
        r_count <= '0;  // Glitch ended, start over
      end else if (r_count == CW'(LEN - 1)) begin
        o_line  <= r_sample;
        r_count <= '0;
      end else begin
        r_count <= r_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/pcu_cfg_pkg.sv
`default_nettype none

package pcu_cfg_pkg;

  localparam int FILTER_LEN  = 8;   // Equal samples before a filter output moves
  localparam int WAIT_STATES = 4;   // Dead time ahead of a new bridge pattern
  localparam int PWM_WIDTH   = 16;  // PWM counter and duty width
  localparam int RAMP_STEPS  = 15;  // Duty steps in the charge ramp

  // One second at a 50 MHz clock
  localparam int STEP_CYCLES_DEFAULT = 50_000_000;

  // Charge duty per ramp step, roughly doubling from step to step.
  // Highest index comes first in the literal below.
  localparam logic [RAMP_STEPS:1][PWM_WIDTH-1:0] PWM_LEVELS = {
    16'd65535,  // Step 15, always on
    16'd33943,
    16'd17580,
    16'd9105,
    16'd4715,
    16'd2441,
    16'd1264,
    16'd654,
    16'd338,
    16'd174,
    16'd90,
    16'd46,
    16'd23,
    16'd11,
    16'd5       // Step 1
  };

endpackage

`default_nettype wire

// File: hw/pcu_top.sv
`default_nettype none

module pcu_top #(
  parameter int STEP_CYCLES = pcu_cfg_pkg::STEP_CYCLES_DEFAULT
) (
  input  wire                         clk,
  input  wire                         rstn,
  input  wire                         i_strobe,
  input  wire [2:0]                   i_cmd_bus,
  input  wire [4:1]                   i_err_dr_n,
  input  wire                         i_err_u_n,
  input  wire                         i_err_i_n,
  input  wire                         i_bt,
  input  wire                         i_stop_k_n,
  output pcu_types_pkg::bridge_out_t  o_bridge,
  output pcu_types_pkg::fault_flags_t o_flags,
  output logic                        o_break,
  output logic                        o_fan,
  output logic                        o_st,
  output logic                        o_charge,
  output logic                        o_ch_pwm,
  output logic                        o_led
);

  logic [11:0]                raw_lines;   // Strobe, bus, then faults as in fault_t
  logic [11:0]                filt_lines;
  pcu_types_pkg::fault_t      w_faults;
  pcu_types_pkg::bridge_out_t w_pattern;
  logic w_fault;
  logic w_ramp_busy, w_ramp_done, w_ramp_begin, w_ramp_abort;
  logic w_load, w_kill, w_pending;

  assign raw_lines = {i_strobe, i_cmd_bus, ~i_err_dr_n, ~i_err_u_n, ~i_err_i_n,
                      i_bt, ~i_stop_k_n};
  assign w_faults  = filt_lines[7:0];
  assign o_break   = w_fault;

  for (genvar gi = 0; gi < 12; gi++) begin : g_filter
    input_filter #(.LEN(pcu_cfg_pkg::FILTER_LEN)) u_filter (
      .clk(clk), .rstn(rstn), .i_line(raw_lines[gi]), .o_line(filt_lines[gi])
    );
  end

  cmd_decoder u_decoder (
    .clk(clk), .rstn(rstn),
    .i_strobe(filt_lines[11]), .i_code(pcu_types_pkg::cmd_code_t'(filt_lines[10:8])),
    .i_fault(w_fault), .i_ramp_busy(w_ramp_busy), .i_ramp_done(w_ramp_done),
    .i_bridge_pending(w_pending), .o_ramp_begin(w_ramp_begin), .o_ramp_abort(w_ramp_abort),
    .o_bridge_load(w_load), .o_bridge_pattern(w_pattern), .o_bridge_kill(w_kill),
    .o_fan(o_fan)
  );

  soft_start #(.STEP_CYCLES(STEP_CYCLES)) u_soft_start (
    .clk(clk), .rstn(rstn), .i_begin(w_ramp_begin), .i_abort(w_ramp_abort),
    .o_busy(w_ramp_busy), .o_done(w_ramp_done), .o_st(o_st), .o_charge(o_charge),
    .o_ch_pwm(o_ch_pwm)
  );

  bridge_driver u_bridge (
    .clk(clk), .rstn(rstn), .i_load(w_load), .i_pattern(w_pattern), .i_kill(w_kill),
    .o_pending(w_pending), .o_bridge(o_bridge)
  );

  fault_monitor #(.STEP_CYCLES(STEP_CYCLES)) u_faults (
    .clk(clk), .rstn(rstn), .i_faults(w_faults), .o_fault(w_fault), .o_flags(o_flags),
    .o_led(o_led)
  );

endmodule

`default_nettype wire

// File: hw/pcu_types_pkg.sv
`default_nettype none

package pcu_types_pkg;

  // Codes on the 3-bit command bus
  typedef enum logic [2:0] {
    CMD_PAUSE     = 3'd0,
    CMD_PLUS      = 3'd1,
    CMD_MINUS     = 3'd2,
    CMD_BALLAST_P = 3'd3,
    CMD_BALLAST_N = 3'd4,
    CMD_START     = 3'd5,
    CMD_SHUTDOWN  = 3'd6,
    CMD_DISCHARGE = 3'd7
  } cmd_code_t;

  // H-bridge switch pattern with its direction indicators
  typedef struct packed {
    logic [4:1] top;      // High-side switches
    logic [4:1] bot;      // Low-side switches
    logic       plus;
    logic       minus;
    logic       pause_p;  // Ballast, positive
    logic       pause_n;  // Ballast, negative
  } bridge_out_t;

  // Filtered fault sources, active high
  typedef struct packed {
    logic [4:1] err_dr;   // Gate driver errors
    logic       err_u;    // Overvoltage
    logic       err_i;    // Overcurrent
    logic       bt;       // Overtemperature
    logic       stop_k;   // Emergency stop
  } fault_t;

  // Sticky indicator outputs
  typedef struct packed {
    logic       stop;
    logic       avv;
    logic       avi;
    logic       td;
    logic [4:1] erbd;
  } fault_flags_t;

endpackage

`default_nettype wire

// File: hw/soft_start.sv
`default_nettype none

module soft_start #(
  parameter int STEP_CYCLES = pcu_cfg_pkg::STEP_CYCLES_DEFAULT
) (
  input  wire  clk,
  input  wire  rstn,
  input  wire  i_begin,
  input  wire  i_abort,
  output logic o_busy,
  output logic o_done,
  output logic o_st,
  output logic o_charge,
  output logic o_ch_pwm
);

  localparam int TW = $clog2(STEP_CYCLES);
  localparam int SW = $clog2(pcu_cfg_pkg::RAMP_STEPS + 1);
  localparam int PW = pcu_cfg_pkg::PWM_WIDTH;

  logic [TW-1:0] r_timer;    // Cycles left in the current step
  logic [SW-1:0] r_step;     // Current ramp step, 1 based
  logic [PW-1:0] r_duty;
  logic [PW-1:0] r_pwm_cnt;

  // Full duty keeps the output high through the counter wrap
  assign o_ch_pwm = o_charge & ((r_pwm_cnt < r_duty) | (&r_duty));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      r_timer   <= '0;
      r_step    <= '0;
      r_duty    <= '0;
      r_pwm_cnt <= '0;
      o_busy    <= 1'b0;
      o_done    <= 1'b0;
      o_st      <= 1'b0;
      o_charge  <= 1'b0;
    end else begin
      r_pwm_cnt <= r_pwm_cnt + 1'b1;
      o_done    <= 1'b0;
      if (i_abort) begin
        r_timer  <= '0;
        r_step   <= '0;
        r_duty   <= '0;
        o_busy   <= 1'b0;
        o_st     <= 1'b0;
        o_charge <= 1'b0;
      end else if (i_begin) begin
        r_timer  <= TW'(STEP_CYCLES - 1);
        r_step   <= SW'(1);
        r_duty   <= pcu_cfg_pkg::PWM_LEVELS[1];
        o_busy   <= 1'b1;
        o_st     <= 1'b0;
        o_charge <= 1'b1;
      end else if (o_busy) begin
        if (r_timer != '0) begin
          r_timer <= r_timer - 1'b1;
        end else begin
          r_timer <= TW'(STEP_CYCLES - 1);
          if (o_st) begin
            r_step   <= '0;  // Hold step after st is over
            r_duty   <= '0;
            o_charge <= 1'b0;
            o_busy   <= 1'b0;
            o_done   <= 1'b1;
          end else if (r_step == SW'(pcu_cfg_pkg::RAMP_STEPS)) begin
            o_st <= 1'b1;
          end else begin
            r_step <= r_step + 1'b1;
            r_duty <= pcu_cfg_pkg::PWM_LEVELS[r_step + 1'b1];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: sources.f
hw/pcu_cfg_pkg.sv
hw/pcu_types_pkg.sv
hw/input_filter.sv
hw/cmd_decoder.sv
hw/soft_start.sv
hw/bridge_driver.sv
hw/fault_monitor.sv
hw/pcu_top.sv
test/tb_pcu.sv

// File: test/tb_pcu.sv
`default_nettype none

module tb_pcu;

  localparam int STEP = 64;  // Short ramp step for simulation
  localparam int FL   = pcu_cfg_pkg::FILTER_LEN;
  localparam int WS   = pcu_cfg_pkg::WAIT_STATES;

  logic                        clk;
  logic                        rstn;
  logic                        strobe;
  logic [2:0]                  cmd_bus;
  logic [4:1]                  err_dr_n;
  logic                        err_u_n;
  logic                        err_i_n;
  logic                        bt;
  logic                        stop_k_n;
  pcu_types_pkg::bridge_out_t  bridge;
  pcu_types_pkg::fault_flags_t flags;
  logic                        brk;
  logic                        fan;
  logic                        st;
  logic                        charge;
  logic                        ch_pwm;
  logic                        led;
  int                          checks = 0;
  int                          errors = 0;
  int                          timeouts = 0;

  pcu_top #(.STEP_CYCLES(STEP)) uut (
    .clk(clk), .rstn(rstn), .i_strobe(strobe), .i_cmd_bus(cmd_bus),
    .i_err_dr_n(err_dr_n), .i_err_u_n(err_u_n), .i_err_i_n(err_i_n), .i_bt(bt),
    .i_stop_k_n(stop_k_n), .o_bridge(bridge), .o_flags(flags), .o_break(brk),
    .o_fan(fan), .o_st(st), .o_charge(charge), .o_ch_pwm(ch_pwm), .o_led(led)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("ERR %0t: %s", $time, what);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timed out at %0t while waiting for %s", $time, what);
  endtask

  task automatic tick(input int n);
    repeat (n) @(negedge clk);  // Drive and sample on the falling edge
  endtask

  // Expected switch pattern built from the numbers of the closed switches
  function automatic pcu_types_pkg::bridge_out_t make_pattern(input int t, input int b,
                                                              input logic [3:0] flag);
    pcu_types_pkg::bridge_out_t p;
    p = '0;
    p.top = 4'(1 << (t - 1));
    p.bot = 4'(1 << (b - 1));
    {p.plus, p.minus, p.pause_p, p.pause_n} = flag;
    return p;
  endfunction

  function automatic pcu_types_pkg::bridge_out_t pattern_for(input pcu_types_pkg::cmd_code_t c);
    case (c)
      pcu_types_pkg::CMD_PLUS:      return make_pattern(1, 2, 4'b1000);
      pcu_types_pkg::CMD_MINUS:     return make_pattern(2, 1, 4'b0100);
      pcu_types_pkg::CMD_BALLAST_P: return make_pattern(3, 4, 4'b0010);
      pcu_types_pkg::CMD_BALLAST_N: return make_pattern(4, 3, 4'b0001);
      default:                      return '0;
    endcase
  endfunction

  function automatic logic probe(input string name);
    case (name)
      "st":     return st;
      "charge": return charge;
      "brk":    return brk;
      default:  return 1'bx;
    endcase
  endfunction

  task automatic apply_reset();
    rstn     = 1'b0;
    strobe   = 1'b0;
    cmd_bus  = 3'd0;
    err_dr_n = 4'hf;  // Fault lines idle
    err_u_n  = 1'b1;
    err_i_n  = 1'b1;
    bt       = 1'b0;
    stop_k_n = 1'b1;
    tick(10);
    rstn = 1'b1;
    tick(2);
  endtask

  // Leaves the strobe just lowered so callers can watch the response
  task automatic strobe_code(input pcu_types_pkg::cmd_code_t code);
    cmd_bus = code;
    tick(2 * FL);
    strobe = 1'b1;
    tick(2 * FL);
    strobe = 1'b0;
  endtask

  task automatic send_cmd(input pcu_types_pkg::cmd_code_t code);
    strobe_code(code);
    tick(2 * FL);
  endtask

  task automatic wait_level(input string name, input logic level, input int limit,
                            output int n);
    n = 0;
    while (probe(name) !== level && n < limit) begin
      tick(1);
      n++;
    end
    if (probe(name) !== level) report_timeout($sformatf("%s to become %b", name, level));
  endtask

  // Counts the all-off cycles seen just before the pattern shows up
  task automatic wait_bridge(input pcu_types_pkg::bridge_out_t exp, input int limit,
                             output int dead);
    int n;
    n = 0;
    dead = 0;
    while (bridge !== exp && n < limit) begin
      dead = (bridge == '0) ? dead + 1 : 0;
      tick(1);
      n++;
    end
    if (bridge !== exp) report_timeout($sformatf("bridge pattern %h", exp));
  endtask

  task automatic led_interval(input int limit, output int n);
    logic prev;
    prev = led;
    n = 0;
    while (led === prev && n < limit) begin
      tick(1);
      n++;
    end
    if (led === prev) report_timeout("the first toggle of o_led");
    prev = led;
    n = 0;
    while (led === prev && n < limit) begin
      tick(1);
      n++;
    end
    if (led === prev) report_timeout("the second toggle of o_led");
  endtask

  task automatic charge_up();
    int n;
    send_cmd(pcu_types_pkg::CMD_START);
    send_cmd(pcu_types_pkg::CMD_PAUSE);
    wait_level("st", 1'b1, 17 * STEP, n);
    wait_level("charge", 1'b0, 2 * STEP, n);
  endtask

  task automatic reset_defaults();
    int n;
    apply_reset();
    check_true(bridge == '0 && flags == '0, "bridge or flags set after reset");
    check_true(!fan && !st && !charge && !brk, "control output set after reset");
    led_interval(2 * STEP, n);
    check_true(n >= STEP - 2 && n <= STEP + 2, $sformatf("LED interval %0d", n));
  endtask

  task automatic soft_start_ramp();
    int   n;
    logic seen_hi;
    logic seen_lo;
    apply_reset();
    send_cmd(pcu_types_pkg::CMD_PLUS);
    tick(FL);
    check_true(bridge == '0, "PLUS before start drove the bridge");
    send_cmd(pcu_types_pkg::CMD_START);
    strobe_code(pcu_types_pkg::CMD_PAUSE);
    wait_level("charge", 1'b1, 4 * FL, n);
    check_true(fan, "fan low after start");
    seen_hi = 1'b0;
    seen_lo = 1'b0;
    n = 0;
    while (!st && n < 16 * STEP) begin
      if (ch_pwm) begin
        seen_hi = 1'b1;
      end else begin
        seen_lo = 1'b1;
      end
      tick(1);
      n++;
    end
    if (!st) report_timeout("o_st to rise");
    check_true(seen_hi && seen_lo, "o_ch_pwm did not toggle during the ramp");
    check_true(n >= 15 * STEP && n * 5 <= 76 * STEP, $sformatf("st after %0d cycles", n));
    wait_level("charge", 1'b0, 2 * STEP, n);
    check_true(n >= STEP - 2 && n <= STEP + 2, $sformatf("charge fell after %0d", n));
    send_cmd(pcu_types_pkg::CMD_PLUS);
    wait_bridge(pattern_for(pcu_types_pkg::CMD_PLUS), 4 * FL, n);
  endtask

  task automatic bridge_patterns();
    pcu_types_pkg::cmd_code_t codes[4];
    int                       dead;
    codes = '{pcu_types_pkg::CMD_PLUS, pcu_types_pkg::CMD_MINUS,
              pcu_types_pkg::CMD_BALLAST_P, pcu_types_pkg::CMD_BALLAST_N};
    apply_reset();
    charge_up();
    // Start from a live pattern so the first command also shows its dead time
    send_cmd(pcu_types_pkg::CMD_BALLAST_N);
    wait_bridge(pattern_for(pcu_types_pkg::CMD_BALLAST_N), 4 * FL, dead);
    foreach (codes[i]) begin
      strobe_code(codes[i]);
      wait_bridge(pattern_for(codes[i]), 4 * FL, dead);
      check_true(dead >= WS, $sformatf("dead time %0d for code %0d", dead, codes[i]));
      tick(2 * FL);
    end
    send_cmd(pcu_types_pkg::CMD_PAUSE);
    check_true(bridge == '0, "PAUSE did not clear the bridge");
  endtask

  task automatic discharge_and_shutdown();
    int n;
    apply_reset();
    send_cmd(pcu_types_pkg::CMD_SHUTDOWN);
    send_cmd(pcu_types_pkg::CMD_DISCHARGE);
    send_cmd(pcu_types_pkg::CMD_PAUSE);
    send_cmd(pcu_types_pkg::CMD_DISCHARGE);
    send_cmd(pcu_types_pkg::CMD_PAUSE);
    send_cmd(pcu_types_pkg::CMD_MINUS);
    wait_bridge(pattern_for(pcu_types_pkg::CMD_MINUS), 4 * FL, n);
    check_true(!charge && !st, "discharge sequence started a ramp");
    send_cmd(pcu_types_pkg::CMD_SHUTDOWN);
    check_true(bridge == '0, "SHUTDOWN left the bridge on");
    send_cmd(pcu_types_pkg::CMD_PLUS);
    tick(FL);
    check_true(bridge == '0, "PLUS accepted after SHUTDOWN");
    send_cmd(pcu_types_pkg::CMD_START);
    send_cmd(pcu_types_pkg::CMD_PAUSE);
    check_true(fan && charge, "ramp did not start after SHUTDOWN");
    send_cmd(pcu_types_pkg::CMD_SHUTDOWN);
    check_true(!fan && !charge, "SHUTDOWN left fan or ramp on");
  endtask

  task automatic fault_handling();
    int                          n;
    pcu_types_pkg::fault_flags_t exp_flags;
    exp_flags         = '0;
    exp_flags.erbd[3] = 1'b1;
    apply_reset();
    charge_up();
    send_cmd(pcu_types_pkg::CMD_PLUS);
    wait_bridge(pattern_for(pcu_types_pkg::CMD_PLUS), 4 * FL, n);
    err_dr_n[3] = 1'b0;  // Glitch shorter than the filter
    tick(FL - 3);
    err_dr_n[3] = 1'b1;
    tick(2 * FL);
    check_true(flags == '0 && !brk, "short driver error pulse latched a fault");
    check_true(bridge == pattern_for(pcu_types_pkg::CMD_PLUS), "glitch disturbed bridge");
    err_dr_n[3] = 1'b0;
    wait_level("brk", 1'b1, 4 * FL, n);
    tick(2);
    check_true(flags == exp_flags, $sformatf("flags %h after driver error", flags));
    check_true(fan && bridge == '0 && !st, "fault did not stop the converter");
    err_dr_n[3] = 1'b1;
    tick(2 * FL);
    check_true(flags == exp_flags && brk, "fault indication lost after release");
    send_cmd(pcu_types_pkg::CMD_PLUS);
    send_cmd(pcu_types_pkg::CMD_START);
    send_cmd(pcu_types_pkg::CMD_PAUSE);
    check_true(bridge == '0 && !charge, "command accepted during fault");
    led_interval(2 * STEP, n);
    check_true(n >= STEP / 8 - 2 && n <= STEP / 8 + 2, $sformatf("fault LED interval %0d", n));
  endtask

  initial begin
    reset_defaults();
    soft_start_ramp();
    bridge_patterns();
    discharge_and_shutdown();
    fault_handling();
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
